// File: design/cache_pkg.sv
// Shared definitions for the direct-mapped write-through cache
// Widths, address field sizes and the packed request and line types

package cache_pkg;

  localparam int addr_w         = 32;                     // Byte address
  localparam int word_w         = 32;                     // CPU word
  localparam int word_bytes     = word_w / 8;
  localparam int line_bytes     = 16;
  localparam int line_w         = line_bytes * 8;
  localparam int off_w          = $clog2(line_bytes);     // Byte offset inside a line
  localparam int words_per_line = line_bytes / word_bytes;
  localparam int sel_w          = $clog2(words_per_line); // Word select inside a line

  // CPU request, one word per strobe
  typedef struct packed {
    logic [addr_w-1:0]     addr;
    logic                  write;  // 1 = store, 0 = load
    logic [word_w-1:0]     wdata;
    logic [word_bytes-1:0] be;     // Byte enables, stores only
  } cpu_req_t;

  // Backing memory request
  // Reads use a line-aligned address, writes carry a single word
  typedef struct packed {
    logic [addr_w-1:0]     addr;
    logic                  write;
    logic [word_w-1:0]     wdata;
    logic [word_bytes-1:0] be;
  } mem_req_t;

  // One cache line seen as bytes, byte 0 at the lowest address
  typedef logic [line_bytes-1:0][7:0] line_t;

endpackage

// File: design/cache_memory.sv
// Cache line data array, single clock
// Port a writes per byte, port b reads with one cycle of latency
// Same-set access on both ports returns the new data (write-first)

module cache_memory import cache_pkg::*; #(
  parameter int sets = 64,                     // Number of lines
  localparam int idx_w = $clog2(sets)
) (
  input  logic                  clka,
  input  logic                  ena,           // Port a enable
  input  logic [line_bytes-1:0] wea,           // Byte write mask
  input  logic [idx_w-1:0]      addra,
  input  line_t                 dina,
  input  logic [idx_w-1:0]      addrb,
  output line_t                 doutb
);

  line_t ram [sets] = '{default: '0};  // Lines start out cleared
  line_t ram_data_a;                   // Port a view after this cycle's write
  line_t ram_data_b;                   // Port b registered read
  logic  last_addr_eq;                 // Both ports addressed the same set

  // Byte-wise write on port a
  always_ff @(posedge clka) begin
    for (int i = 0; i < line_bytes; i++) begin
      if (ena && wea[i]) begin
        ram[addra][i] <= dina[i];
      end
    end
  end

  // Port a data register, new bytes win over stored ones
  always_ff @(posedge clka) begin
    for (int i = 0; i < line_bytes; i++) begin
      if (ena && wea[i]) begin
        ram_data_a[i] <= dina[i];
      end else begin
        ram_data_a[i] <= ram[addra][i];
      end
    end
  end

  always_ff @(posedge clka) begin
    ram_data_b   <= ram[addrb];     // Old contents if written this cycle
    last_addr_eq <= addra == addrb;
  end

  // Forward port a data on a same-set collision
  assign doutb = last_addr_eq ? ram_data_a : ram_data_b;

  // Controller only drives byte strobes with the port enabled
  a_wea_needs_ena: assert property (@(posedge clka) !ena |-> wea == '0)
    else $error("cache_memory: byte write mask set while port a disabled");

endmodule

// File: design/tag_array.sv
// Tag store with one valid bit per set
// Lookup is registered, hit comes one cycle after the index
// A write to the looked-up set forwards the new tag to the compare

module tag_array import cache_pkg::*; #(
  parameter int sets = 64,
  localparam int idx_w = $clog2(sets),
  localparam int tag_w = addr_w - idx_w - off_w
) (
  input  logic             clka,
  input  logic             reset,
  input  logic [idx_w-1:0] index,  // Set under lookup and refill target
  input  logic [tag_w-1:0] tag,    // Compare tag, also the refill tag
  input  logic             wr,     // Refill, stores tag and sets valid
  output logic             hit
);

  logic [tag_w-1:0] tags [sets];   // Meaningless until the valid bit is set
  logic [sets-1:0]  valid;
  logic [tag_w-1:0] tag_q;         // Stored tag of the looked-up set
  logic             valid_q;
  logic [tag_w-1:0] tag_in_q;      // Incoming tag, lined up with tag_q

  always_ff @(posedge clka) begin
    if (wr) begin
      tags[index] <= tag;
    end
  end

  always_ff @(posedge clka) begin
    if (reset) begin
      valid   <= '0;               // Cold cache
      valid_q <= 1'b0;
    end else begin
      if (wr) begin
        valid[index] <= 1'b1;
      end
      valid_q <= wr | valid[index]; // Refill to this set counts right away
    end
  end

  always_ff @(posedge clka) begin
    tag_q    <= wr ? tag : tags[index];
    tag_in_q <= tag;
  end

  assign hit = valid_q && (tag_q == tag_in_q);

endmodule

// File: design/cache_ctrl.sv
// Cache controller FSM
// Handles lookup, line refill on read miss, write-through and the CPU response
// Write misses go to memory only, no line is allocated

module cache_ctrl import cache_pkg::*; #(
  parameter int sets = 64,
  localparam int idx_w = $clog2(sets),
  localparam int tag_w = addr_w - idx_w - off_w
) (
  input  logic                  clka,
  input  logic                  reset,
  input  logic                  cpu_req,       // Request strobe
  input  cpu_req_t              cpu_req_data,
  output logic                  busy,
  output logic                  resp_valid,    // Response pulse
  output logic [sel_w-1:0]      word_sel,      // Word lane of the held request
  input  logic                  hit,
  output logic [idx_w-1:0]      tag_index,
  output logic [tag_w-1:0]      tag_value,
  output logic                  tag_wr,
  output logic                  ram_ena,
  output logic [line_bytes-1:0] ram_wea,
  output logic [idx_w-1:0]      ram_addra,
  output line_t                 ram_dina,
  output logic [idx_w-1:0]      ram_addrb,
  output logic                  mem_req,       // Memory request strobe
  output mem_req_t              mem_req_data,
  input  logic                  mem_ack,
  input  line_t                 mem_rline
);

  typedef enum logic [2:0] {
    idle, lookup, write_through, refill_wait, refill_read, respond
  } state_t;

  state_t   state, state_nxt;
  cpu_req_t req_q;                 // Request being served
  logic     hit_vld;               // Tag compare result ready this cycle
  logic     decide;                // Last lookup cycle
  logic     wr_hit;                // Store merges into the cached line
  logic     accept;
  logic     mem_req_q;
  mem_req_t mem_req_data_q;

  logic [idx_w-1:0]      req_index;
  logic [sel_w-1:0]      word_off;
  logic [line_bytes-1:0] be_shift;
  line_t                 word_shift;

  assign req_index = req_q.addr[off_w +: idx_w];
  assign word_off  = req_q.addr[off_w-1 -: sel_w];
  assign be_shift  = line_bytes'(req_q.be) << (word_off * word_bytes);  // Byte lane
  assign word_shift = line_w'(req_q.wdata) << (word_off * word_w);

  assign accept = cpu_req && !busy;
  assign decide = (state == lookup) && hit_vld;
  assign wr_hit = decide && hit && req_q.write;

  always_comb begin
    state_nxt = state;
    case (state)
      idle:          if (cpu_req) state_nxt = lookup;
      lookup: begin
        if (hit_vld) begin
          if (req_q.write)  state_nxt = write_through; // Stores always go to memory
          else if (hit)     state_nxt = respond;
          else              state_nxt = refill_wait;
        end
      end
      write_through: if (mem_ack) state_nxt = respond;
      refill_wait:   if (mem_ack) state_nxt = refill_read;
      refill_read:   state_nxt = respond;           // Refilled line read back on port b
      respond:       state_nxt = cpu_req ? lookup : idle; // Back-to-back request
      default:       state_nxt = idle;
    endcase
  end

  always_ff @(posedge clka) begin
    if (reset) begin
      state     <= idle;
      hit_vld   <= 1'b0;
      mem_req_q <= 1'b0;
    end else begin
      state     <= state_nxt;
      hit_vld   <= (state == lookup) && !hit_vld; // Tag pipeline takes one cycle
      mem_req_q <= decide && (req_q.write || !hit);
    end
  end

  always_ff @(posedge clka) begin
    if (accept) begin
      req_q <= cpu_req_data;
    end
    if (decide) begin
      mem_req_data_q <= '{addr:  req_q.write ? req_q.addr
                                             : {req_q.addr[addr_w-1:off_w], off_w'(0)},
                          write: req_q.write,
                          wdata: req_q.wdata,
                          be:    req_q.write ? req_q.be : '1};
    end
  end

  assign busy       = (state != idle) && (state != respond); // Low again with the response
  assign resp_valid = state == respond;
  assign word_sel   = word_off;

  assign tag_index = req_index;
  assign tag_value = req_q.addr[addr_w-1 -: tag_w];
  assign tag_wr    = (state == refill_wait) && mem_ack;  // Line and tag land together

  assign ram_ena   = tag_wr || wr_hit;
  assign ram_wea   = tag_wr ? '1 : (wr_hit ? be_shift : '0);
  assign ram_addra = req_index;
  assign ram_dina  = tag_wr ? mem_rline : word_shift;
  assign ram_addrb = req_index;

  assign mem_req      = mem_req_q;
  assign mem_req_data = mem_req_data_q;

  a_req_not_busy: assert property (@(posedge clka) disable iff (reset) cpu_req |-> !busy)
    else $error("cache_ctrl: CPU request while busy");
  a_ack_outstanding: assert property (@(posedge clka) disable iff (reset)
    mem_ack |-> (state == write_through || state == refill_wait) && !mem_req_q)
    else $error("cache_ctrl: memory ack without a pending request");
  a_resp_pulse: assert property (@(posedge clka) disable iff (reset)
    resp_valid |=> !resp_valid)
    else $error("cache_ctrl: response held for more than one cycle");

endmodule

// File: design/cache_top.sv
// Direct-mapped write-through cache, top level
// Joins controller, tag store and line array and picks the response word

module cache_top import cache_pkg::*; #(
  parameter int sets = 64                 // Power of two, 2 or more
) (
  input  logic              clka,
  input  logic              reset,
  input  logic              cpu_req,
  input  cpu_req_t          cpu_req_data,
  output logic              busy,
  output logic              resp_valid,
  output logic [word_w-1:0] resp_rdata,  // Load data, don't care on stores
  output logic              mem_req,
  output mem_req_t          mem_req_data,
  input  logic              mem_ack,
  input  line_t             mem_rline
);

  localparam int idx_w = $clog2(sets);
  localparam int tag_w = addr_w - idx_w - off_w;

  logic                  hit;
  logic [idx_w-1:0]      tag_index;
  logic [tag_w-1:0]      tag_value;
  logic                  tag_wr;
  logic                  ram_ena;
  logic [line_bytes-1:0] ram_wea;
  logic [idx_w-1:0]      ram_addra, ram_addrb;
  line_t                 ram_dina, ram_doutb;
  logic [sel_w-1:0]      word_sel;

  cache_ctrl #(.sets(sets)) ctrl0 (
    .clka, .reset, .cpu_req, .cpu_req_data, .busy, .resp_valid, .word_sel,
    .hit, .tag_index, .tag_value, .tag_wr,
    .ram_ena, .ram_wea, .ram_addra, .ram_dina, .ram_addrb,
    .mem_req, .mem_req_data, .mem_ack, .mem_rline
  );

  tag_array #(.sets(sets)) tags0 (
    .clka, .reset, .index(tag_index), .tag(tag_value), .wr(tag_wr), .hit
  );

  cache_memory #(.sets(sets)) data0 (
    .clka, .ena(ram_ena), .wea(ram_wea), .addra(ram_addra), .dina(ram_dina),
    .addrb(ram_addrb), .doutb(ram_doutb)
  );

  assign resp_rdata = ram_doutb[word_sel*word_bytes +: word_bytes]; // Word lane of the line

endmodule

// File: tb/backing_mem.sv
// Behavioral backing memory for the cache testbench
// Serves line reads and word writes after a random delay of 1 to 4 cycles

module backing_mem import cache_pkg::*; (
  input  logic     clka,
  input  logic     reset,
  input  logic     mem_req,       // Request strobe from the DUT
  input  mem_req_t mem_req_data,
  output logic     mem_ack,       // One-cycle pulse
  output line_t    mem_rline      // Line data, valid with mem_ack on reads
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] mem [bit [31:0]];   // Sparse, only written bytes are stored
  integer     seed = 37;
  logic       pending = 1'b0;     // Request accepted, not yet answered
  int         wait_n;             // Cycles left until mem_ack
  mem_req_t   req;

  // Untouched bytes fold the whole address into one byte
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
  endfunction

  function automatic logic [7:0] rd_byte(input logic [31:0] a);
    return mem.exists(a) ? mem[a] : fill_byte(a);
  endfunction

  initial begin
    mem_ack   = 1'b0;
    mem_rline = '0;
  end

  // Outputs change on the falling edge, DUT samples on the rising one
  always @(negedge clka) begin
    if (reset) begin
      pending = 1'b0;
      mem_ack = 1'b0;
    end else begin
      mem_ack = 1'b0;                 // Pulse lasts one cycle
      if (pending) begin
        wait_n--;
        if (wait_n == 0) begin
          if (req.write) begin
            for (int i = 0; i < word_bytes; i++) begin
              if (req.be[i]) mem[{req.addr[31:2], 2'b00} + 32'(i)] = req.wdata[8*i +: 8];
            end
          end else begin
            for (int i = 0; i < line_bytes; i++) begin
              mem_rline[i] = rd_byte({req.addr[31:4], 4'h0} + 32'(i));
            end
          end
          mem_ack = 1'b1;
          pending = 1'b0;
        end
      end else if (mem_req) begin
        req     = mem_req_data;
        pending = 1'b1;
        wait_n  = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
      end
    end
  end

endmodule

// File: tb/cache_tb.sv
// Testbench for the direct-mapped write-through cache
// Directed hit, miss, write and conflict cases, then random traffic
// Results are checked against a shadow memory and a shadow tag store

module cache_tb import cache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int sets     = 64;
  localparam int idx_w    = $clog2(sets);
  localparam int tag_w    = addr_w - idx_w - off_w;
  localparam int wait_max = 200;           // Cycle limit of every wait loop

  logic              clka;
  logic              reset;
  logic              cpu_req;
  cpu_req_t          cpu_req_data;
  logic              busy;
  logic              resp_valid;
  logic [word_w-1:0] resp_rdata;
  logic              mem_req;
  mem_req_t          mem_req_data;
  logic              mem_ack;
  line_t             mem_rline;

  integer seed;
  int     cyc        = 0;                  // Rising edges so far
  int     mem_reads  = 0;                  // Seen on the memory bus
  int     mem_writes = 0;
  int     exp_reads  = 0;                  // Predicted from the shadow tags
  int     exp_writes = 0;

  logic        pend_open = 1'b0;           // Request issued, no response yet
  logic        pend_write;
  logic        pend_hit;                   // Predicted tag hit
  logic [31:0] pend_addr;
  logic [31:0] pend_wdata;
  logic [3:0]  pend_be;
  int          pend_cycle;                 // Edge that sampled the strobe

  logic [7:0]       shadow [bit [31:0]];   // Expected memory contents
  logic             pv_valid [sets] = '{default: 1'b0};
  logic [tag_w-1:0] pv_tag [sets];

  cache_top #(.sets(sets)) dut0 (
    .clka, .reset, .cpu_req, .cpu_req_data, .busy, .resp_valid, .resp_rdata,
    .mem_req, .mem_req_data, .mem_ack, .mem_rline
  );

  backing_mem mem0 (.clka, .reset, .mem_req, .mem_req_data, .mem_ack, .mem_rline);

  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;               // 100 MHz
  end

  always @(posedge clka) cyc <= cyc + 1;

  task automatic halt_on_failure();
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_val(input string name, input logic [63:0] act,
                             input logic [63:0] exp);
    if (act !== exp) begin
      $display("[ERROR] t=%0d ns %s: got 0x%0h, expected 0x%0h", $time, name, act, exp);
      halt_on_failure();
    end
  endtask

  function automatic logic [7:0] init_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];  // Start pattern of the memory
  endfunction

  // Expected load result, little-endian word from the shadow
  function automatic logic [31:0] exp_word(input logic [31:0] addr);
    logic [31:0] w;
    logic [31:0] a;
    for (int i = 0; i < word_bytes; i++) begin
      a = {addr[31:2], 2'b00} + 32'(i);
      w[8*i +: 8] = shadow.exists(a) ? shadow[a] : init_byte(a);
    end
    return w;
  endfunction

  // One CPU access, waits for its response
  task automatic do_access(input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
    int               n;
    logic [idx_w-1:0] idx;
    logic [tag_w-1:0] tag;
    n = 0;
    while (busy) begin
      if (n == wait_max) begin
        $display("Timeout: cache stayed busy before a new request");
        halt_on_failure();
      end
      @(negedge clka);
      n++;
    end
    idx        = addr[off_w +: idx_w];
    tag        = addr[addr_w-1 -: tag_w];
    pend_write = wr;
    pend_addr  = addr;
    pend_wdata = wdata;
    pend_be    = be;
    pend_cycle = cyc + 1;
    pend_hit   = pv_valid[idx] && (pv_tag[idx] == tag);
    pend_open  = 1'b1;
    if (wr) begin
      exp_writes++;                        // Every store goes through
      for (int i = 0; i < word_bytes; i++) begin
        if (be[i]) shadow[{addr[31:2], 2'b00} + 32'(i)] = wdata[8*i +: 8];
      end
    end else if (!pend_hit) begin
      exp_reads++;                         // Load miss refills the set
      pv_valid[idx] = 1'b1;
      pv_tag[idx]   = tag;
    end
    cpu_req      = 1'b1;
    cpu_req_data = '{addr: addr, write: wr, wdata: wdata, be: be};
    @(negedge clka);
    cpu_req = 1'b0;
    compare_val("busy", 64'(busy), 64'd1);   // Rises after the accepted strobe
    n = 0;
    while (!resp_valid) begin
      if (n == wait_max) begin
        $display("Timeout: no response within %0d cycles for address 0x%08h", wait_max, addr);
        halt_on_failure();
      end
      @(negedge clka);
      n++;
    end
    @(negedge clka);                       // Compare process sees this response first
  endtask

  // Monitor and compare, outputs are stable at the falling edge
  always @(negedge clka) begin
    if (reset === 1'b0) begin
      if (mem_req) begin
        if (mem_req_data.write) begin
          mem_writes++;
          compare_val("mem_req_data.addr", 64'(mem_req_data.addr), 64'(pend_addr));
          compare_val("mem_req_data.wdata", 64'(mem_req_data.wdata), 64'(pend_wdata));
          compare_val("mem_req_data.be", 64'(mem_req_data.be), 64'(pend_be));
        end else begin
          mem_reads++;
          compare_val("mem_req_data.addr", 64'(mem_req_data.addr),
                      64'({pend_addr[31:4], 4'h0}));  // Line aligned
        end
      end
      if (resp_valid) begin
        if (!pend_open) begin
          $display("Response pulse without an outstanding request");
          halt_on_failure();
        end
        compare_val("busy", 64'(busy), 64'd0);   // Drops with the response
        if (!pend_write) begin
          compare_val("resp_rdata", 64'(resp_rdata), 64'(exp_word(pend_addr)));
          if (pend_hit) compare_val("read hit latency", 64'(cyc - pend_cycle), 64'd2);
        end
        compare_val("mem_reads", 64'(mem_reads), 64'(exp_reads));
        compare_val("mem_writes", 64'(mem_writes), 64'(exp_writes));
        pend_open = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    seed         = 37;
    reset        = 1'b1;
    cpu_req      = 1'b0;
    cpu_req_data = '0;
    repeat (2) @(posedge clka);            // Two reset cycles
    @(negedge clka);
    reset = 1'b0;
    @(negedge clka);
    compare_val("busy", 64'(busy), 64'd0);
    compare_val("resp_valid", 64'(resp_valid), 64'd0);
    compare_val("mem_req", 64'(mem_req), 64'd0);

    do_access(1'b0, 32'h0000_1238, 32'h0, 4'h0);          // Cold miss
    compare_val("mem_reads", 64'(mem_reads), 64'd1);
    do_access(1'b0, 32'h0000_123c, 32'h0, 4'h0);          // Same line, hit
    compare_val("mem_reads", 64'(mem_reads), 64'd1);

    do_access(1'b1, 32'h0000_1238, 32'hdead_beef, 4'b0110);  // Partial write hit
    do_access(1'b0, 32'h0000_1238, 32'h0, 4'h0);
    compare_val("mem_reads", 64'(mem_reads), 64'd1);

    do_access(1'b1, 32'h0000_5670, 32'hcafe_f00d, 4'b1001);  // Write miss
    compare_val("mem_writes", 64'(mem_writes), 64'd2);
    do_access(1'b0, 32'h0000_5670, 32'h0, 4'h0);          // Not allocated, misses
    compare_val("mem_reads", 64'(mem_reads), 64'd2);

    // Same index, different tags
    do_access(1'b0, 32'h0002_0100, 32'h0, 4'h0);
    do_access(1'b0, 32'h0003_0100, 32'h0, 4'h0);
    do_access(1'b0, 32'h0002_0104, 32'h0, 4'h0);
    do_access(1'b0, 32'h0003_0108, 32'h0, 4'h0);
    compare_val("mem_reads", 64'(mem_reads), 64'd6);

    // Small window, 4 tags over 4 sets keeps conflicts frequent
    repeat (300) begin
      r = $random(seed);
      a = 32'h0001_0000 | {20'h0, r[1:0], 4'b0000, r[3:2], r[5:4], 2'b00};
      do_access(r[6], a, $random(seed), r[11:8]);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// File: all.f
design/cache_pkg.sv
design/cache_memory.sv
design/tag_array.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/backing_mem.sv
tb/cache_tb.sv

// File: Makefile
# Verilator build and run for the write-through cache testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cache_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "TEST PASSED" || \
	  (echo "TEST FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
